// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int xlen     = 32;
  localparam int rob_size = 8;                  // tags handed out by the rob
  localparam int tag_w    = $clog2(rob_size);
  localparam int rs_depth = 3;                  // station entries

  typedef logic [tag_w-1:0]       tag_t;
  typedef logic signed [xlen-1:0] word_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,   // signed compare
    op_sltu,  // unsigned compare
    op_sll,
    op_srl,
    op_sra
  } alu_op_e;

  // reference behaviour of the integer alu
  function automatic word_t alu_compute(alu_op_e op, word_t a, word_t b);
    word_t res;
    logic [4:0] shamt;
    shamt = b[4:0];                              // only low five bits shift
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_slt:  res = word_t'(a < b);
      op_sltu: res = word_t'($unsigned(a) < $unsigned(b));
      op_sll:  res = a << shamt;
      op_srl:  res = a >> shamt;                 // zero fill
      op_sra:  res = a >>> shamt;                // sign fill, a is signed
      default: res = '0;                         // unused encodings
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

// File: design/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// one instruction with both operands resolved, station to alu
interface issue_if
  import exec_pkg::*;
();

  logic    valid;  // station holds an instruction
  logic    ready;  // alu stage one can take it
  alu_op_e op;
  tag_t    tag;    // destination rob tag
  word_t   a;      // operand i
  word_t   b;      // operand j

  modport source (
    output valid, op, tag, a, b,
    input  ready
  );

  modport sink (
    input  valid, op, tag, a, b,
    output ready
  );

endinterface

`default_nettype wire

// File: design/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station
  import exec_pkg::*;
(
  input  wire logic    clk_in,
  input  wire logic    rst_in,
  input  wire logic    disp_valid,
  output logic         disp_ready,
  input  wire alu_op_e disp_op,
  input  wire tag_t    disp_tag,
  input  wire logic    disp_i_ready,
  input  wire logic    disp_j_ready,
  input  wire tag_t    disp_i_tag,
  input  wire tag_t    disp_j_tag,
  input  wire word_t   disp_i_value,
  input  wire word_t   disp_j_value,
  input  wire logic    cdb_valid,
  input  wire tag_t    cdb_tag,
  input  wire word_t   cdb_value,
  issue_if.source      issue
);

  typedef logic [$clog2(rs_depth)-1:0] idx_t;

  logic [rs_depth-1:0] busy;     // entry holds an instruction
  logic [rs_depth-1:0] i_rdy;    // operand i has its value
  logic [rs_depth-1:0] j_rdy;
  alu_op_e             ent_op  [rs_depth];
  tag_t                ent_tag [rs_depth];
  tag_t                i_tag   [rs_depth];  // producer tag while waiting
  tag_t                j_tag   [rs_depth];
  word_t               i_val   [rs_depth];
  word_t               j_val   [rs_depth];

  logic [rs_depth-1:0] eligible;
  logic [rs_depth-1:0] i_wake;
  logic [rs_depth-1:0] j_wake;
  idx_t                free_idx;
  idx_t                sel_idx;
  logic                disp_fire;
  logic                sel_load;
  logic                di_hit;
  logic                dj_hit;

  assign disp_ready = ~&busy;                   // any free entry
  assign disp_fire  = disp_valid && disp_ready;
  assign eligible   = busy & i_rdy & j_rdy;

  // issue register is empty or being drained this cycle
  assign sel_load = |eligible && (!issue.valid || issue.ready);

  // a broadcast in the dispatch cycle is caught on the way in
  assign di_hit = cdb_valid && (cdb_tag == disp_i_tag);
  assign dj_hit = cdb_valid && (cdb_tag == disp_j_tag);

  always_comb begin
    free_idx = '0;
    sel_idx  = '0;
    for (int e = rs_depth - 1; e >= 0; e--) begin  // downward so lowest index wins
      if (!busy[e]) free_idx = idx_t'(e);
      if (eligible[e]) sel_idx = idx_t'(e);
      i_wake[e] = busy[e] && !i_rdy[e] && cdb_valid && (cdb_tag == i_tag[e]);
      j_wake[e] = busy[e] && !j_rdy[e] && cdb_valid && (cdb_tag == j_tag[e]);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy  <= '0;
      i_rdy <= '0;
      j_rdy <= '0;
    end else begin
      for (int e = 0; e < rs_depth; e++) begin
        if (disp_fire && free_idx == idx_t'(e)) begin
          busy[e]  <= 1'b1;
          i_rdy[e] <= disp_i_ready || di_hit;
          j_rdy[e] <= disp_j_ready || dj_hit;
        end else begin
          if (sel_load && sel_idx == idx_t'(e)) busy[e] <= 1'b0;  // freed at selection
          if (i_wake[e]) i_rdy[e] <= 1'b1;
          if (j_wake[e]) j_rdy[e] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int e = 0; e < rs_depth; e++) begin
      if (disp_fire && free_idx == idx_t'(e)) begin
        ent_op[e]  <= disp_op;
        ent_tag[e] <= disp_tag;
        i_tag[e]   <= disp_i_tag;
        j_tag[e]   <= disp_j_tag;
        i_val[e]   <= disp_i_ready ? disp_i_value : cdb_value;
        j_val[e]   <= disp_j_ready ? disp_j_value : cdb_value;
      end else begin
        if (i_wake[e]) i_val[e] <= cdb_value;
        if (j_wake[e]) j_val[e] <= cdb_value;
      end
    end
  end

  // registered issue slot held until the alu accepts
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      issue.valid <= 1'b0;
    end else if (sel_load) begin
      issue.valid <= 1'b1;
    end else if (issue.ready) begin
      issue.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (sel_load) begin
      issue.op  <= ent_op[sel_idx];
      issue.tag <= ent_tag[sel_idx];
      issue.a   <= i_val[sel_idx];
      issue.b   <= j_val[sel_idx];
    end
  end

  // a dispatch only ever lands in an empty entry
  a_no_accept_full: assert property (@(posedge clk_in) disable iff (rst_in)
    disp_fire |-> !busy[free_idx]);

  // the entry moved to the issue slot has both operands in hand
  a_no_stale_issue: assert property (@(posedge clk_in) disable iff (rst_in)
    sel_load |-> busy[sel_idx] && i_rdy[sel_idx] && j_rdy[sel_idx]);

  a_issue_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    issue.valid && !issue.ready |=>
      issue.valid && $stable({issue.op, issue.tag, issue.a, issue.b}));

endmodule

`default_nettype wire

// File: design/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe
  import exec_pkg::*;
(
  input  wire logic clk_in,
  input  wire logic rst_in,
  issue_if.sink     issue,
  output logic      result_valid,
  input  wire logic result_ready,
  output tag_t      result_tag,
  output word_t     result_value
);

  logic    s1_valid;   // stage one holds operands
  alu_op_e s1_op;
  tag_t    s1_tag;
  word_t   s1_a;
  word_t   s1_b;

  logic    s2_adv;     // output stage empty or handing off
  logic    s1_adv;

  assign s2_adv      = !result_valid || result_ready;
  assign s1_adv      = !s1_valid || s2_adv;
  assign issue.ready = s1_adv;

  // stage one, operand capture
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
    end else if (s1_adv) begin
      s1_valid <= issue.valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (s1_adv && issue.valid) begin
      s1_op  <= issue.op;
      s1_tag <= issue.tag;
      s1_a   <= issue.a;
      s1_b   <= issue.b;
    end
  end

  // stage two, computed value drives result and cdb
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      result_valid <= 1'b0;
    end else if (s2_adv) begin
      result_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (s2_adv && s1_valid) begin
      result_tag   <= s1_tag;
      result_value <= alu_compute(s1_op, s1_a, s1_b);
    end
  end

  a_result_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    result_valid && !result_ready |=>
      result_valid && $stable(result_tag) && $stable(result_value));

  a_no_valid_in_reset: assert property (@(posedge clk_in)
    rst_in |=> !result_valid);

endmodule

`default_nettype wire

// File: design/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster
  import exec_pkg::*;
(
  input  wire logic    clk_in,
  input  wire logic    rst_in,
  input  wire logic    disp_valid,
  output logic         disp_ready,
  input  wire alu_op_e disp_op,
  input  wire tag_t    disp_tag,
  input  wire logic    disp_i_ready,
  input  wire logic    disp_j_ready,
  input  wire tag_t    disp_i_tag,
  input  wire tag_t    disp_j_tag,
  input  wire word_t   disp_i_value,
  input  wire word_t   disp_j_value,
  output logic         result_valid,
  input  wire logic    result_ready,
  output tag_t         result_tag,
  output word_t        result_value
);

  logic  cdb_valid;
  tag_t  cdb_tag;
  word_t cdb_value;

  // broadcast only on a completed result handshake
  assign cdb_valid = result_valid && result_ready;
  assign cdb_tag   = result_tag;
  assign cdb_value = result_value;

  issue_if i_issue_if ();

  reservation_station i_reservation_station (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .disp_valid   (disp_valid),
    .disp_ready   (disp_ready),
    .disp_op      (disp_op),
    .disp_tag     (disp_tag),
    .disp_i_ready (disp_i_ready),
    .disp_j_ready (disp_j_ready),
    .disp_i_tag   (disp_i_tag),
    .disp_j_tag   (disp_j_tag),
    .disp_i_value (disp_i_value),
    .disp_j_value (disp_j_value),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value),
    .issue        (i_issue_if.source)
  );

  alu_pipe i_alu_pipe (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .issue        (i_issue_if.sink),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_tag   (result_tag),
    .result_value (result_value)
  );

endmodule

`default_nettype wire

// File: bench/exec_cluster_cases.svh
`ifndef EXEC_CLUSTER_CASES_SVH
`define EXEC_CLUSTER_CASES_SVH

// fields op, tag, i from row, i value or row, j from row, j value or row, expected, flags
// flag bit 0 drains and stalls the result port first and bit 1 expects a full station after
localparam int n_cases = 24;

typedef struct packed {
  alu_op_e    op;
  tag_t       tag;
  logic       i_dep;  // i_arg is the index of the producing row
  word_t      i_arg;
  logic       j_dep;
  word_t      j_arg;
  word_t      exp;    // worked out by hand
  logic [1:0] flag;
} case_t;

case_t cases [n_cases];

function automatic void load_cases();
  cases[0]  = '{op_add,  3'd0, 1'b0, 32'sd5,        1'b0, 32'sd7,        32'sd12,       2'd0};
  cases[1]  = '{op_sub,  3'd1, 1'b0, 32'sd3,        1'b0, 32'sd10,       -32'sd7,       2'd0};
  cases[2]  = '{op_and,  3'd2, 1'b0, 32'hf0f01234,  1'b0, 32'h0ff0ff00,  32'h00f01200,  2'd0};
  cases[3]  = '{op_or,   3'd3, 1'b0, 32'h000000f0,  1'b0, 32'h00000f0f,  32'h00000fff,  2'd0};
  cases[4]  = '{op_xor,  3'd4, 1'b0, 32'haaaa5555,  1'b0, 32'hffff0000,  32'h55555555,  2'd0};
  cases[5]  = '{op_slt,  3'd5, 1'b0, -32'sd4,       1'b0, 32'sd3,        32'sd1,        2'd0};
  cases[6]  = '{op_sltu, 3'd6, 1'b0, -32'sd4,       1'b0, 32'sd3,        32'sd0,        2'd0};
  cases[7]  = '{op_sll,  3'd7, 1'b0, 32'sd1,        1'b0, 32'sd36,       32'sd16,       2'd0};
  cases[8]  = '{op_srl,  3'd0, 1'b0, 32'h80000000,  1'b0, 32'sd4,        32'h08000000,  2'd0};
  cases[9]  = '{op_sra,  3'd1, 1'b0, -32'sd256,     1'b0, 32'sd4,        -32'sd16,      2'd0};
  cases[10] = '{op_slt,  3'd2, 1'b0, 32'sd3,        1'b0, -32'sd4,       32'sd0,        2'd0};
  cases[11] = '{op_add,  3'd3, 1'b1, 32'sd0,        1'b1, 32'sd1,        32'sd5,        2'd0};
  cases[12] = '{op_sub,  3'd4, 1'b1, 32'sd11,       1'b1, 32'sd5,        32'sd4,        2'd0};
  cases[13] = '{op_sll,  3'd5, 1'b1, 32'sd12,       1'b1, 32'sd12,       32'sd64,       2'd0};
  cases[14] = '{op_xor,  3'd6, 1'b1, 32'sd13,       1'b1, 32'sd4,        32'h55555515,  2'd0};
  cases[15] = '{op_sra,  3'd7, 1'b1, 32'sd9,        1'b0, 32'sd1,        -32'sd8,       2'd0};
  cases[16] = '{op_or,   3'd0, 1'b1, 32'sd15,       1'b1, 32'sd14,       -32'sd3,       2'd0};
  cases[17] = '{op_add,  3'd1, 1'b0, 32'sd100,      1'b0, 32'sd23,       32'sd123,      2'd1};
  cases[18] = '{op_sub,  3'd2, 1'b1, 32'sd17,       1'b0, 32'sd3,        32'sd120,      2'd0};
  cases[19] = '{op_and,  3'd3, 1'b1, 32'sd17,       1'b0, 32'sd255,      32'sd123,      2'd0};
  cases[20] = '{op_sltu, 3'd4, 1'b1, 32'sd17,       1'b0, 32'sd200,      32'sd1,        2'd2};
  cases[21] = '{op_add,  3'd5, 1'b1, 32'sd18,       1'b1, 32'sd19,       32'sd243,      2'd0};
  cases[22] = '{op_srl,  3'd6, 1'b1, 32'sd16,       1'b1, 32'sd20,       32'h7ffffffe,  2'd0};
  cases[23] = '{op_sub,  3'd7, 1'b1, 32'sd22,       1'b1, 32'sd21,       32'h7fffff0b,  2'd0};
endfunction

`endif

// File: bench/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb
  import exec_pkg::*;
();

  logic    clk_in       = 1'b0;
  logic    rst_in       = 1'b1;
  logic    disp_valid   = 1'b0;
  logic    disp_ready;
  alu_op_e disp_op      = op_add;
  tag_t    disp_tag     = '0;
  logic    disp_i_ready = 1'b0;
  logic    disp_j_ready = 1'b0;
  tag_t    disp_i_tag   = '0;
  tag_t    disp_j_tag   = '0;
  word_t   disp_i_value = '0;
  word_t   disp_j_value = '0;
  logic    result_valid;
  logic    result_ready = 1'b0;
  tag_t    result_tag;
  word_t   result_value;

  `include "exec_cluster_cases.svh"

  int          errors    = 0;
  int          n_results = 0;
  int          n_pending = 0;
  int          hold_cnt  = 0;         // cycles left with result_ready forced low
  logic [31:0] lcg_state = 32'h7bc1;
  logic        sb_pending [rob_size];
  int          sb_row     [rob_size]; // table row owning each tag
  logic        row_done   [n_cases];
  logic        held_valid = 1'b0;     // result was stalled at the last check
  tag_t        held_tag;
  word_t       held_value;

  exec_cluster i_exec_cluster (.*);

  always #2 clk_in = ~clk_in;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_tag(input tag_t got, input tag_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: result tag %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_value(input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: result value %0d, expected %0d", $time, got, exp);
    end
  endtask

  // the hand-written expected values must agree with the reference alu
  task automatic cross_check_table();
    word_t a;
    word_t b;
    for (int r = 0; r < n_cases; r++) begin
      a = cases[r].i_dep ? cases[int'(cases[r].i_arg)].exp : cases[r].i_arg;
      b = cases[r].j_dep ? cases[int'(cases[r].j_arg)].exp : cases[r].j_arg;
      if (alu_compute(cases[r].op, a, b) !== cases[r].exp) begin
        errors++;
        $display("table row %0d disagrees with the reference alu", r);
      end
    end
  endtask

  // waits for room in the station and a free tag and then holds valid for one edge
  task automatic dispatch_row(input int r);
    case_t c;
    c = cases[r];
    while (!disp_ready || sb_pending[c.tag]) begin
      @(posedge clk_in);
      #1;
    end
    disp_op      = c.op;
    disp_tag     = c.tag;
    disp_i_ready = !c.i_dep || row_done[int'(c.i_arg)];
    disp_j_ready = !c.j_dep || row_done[int'(c.j_arg)];
    disp_i_tag   = c.i_dep ? cases[int'(c.i_arg)].tag : '0;
    disp_j_tag   = c.j_dep ? cases[int'(c.j_arg)].tag : '0;
    disp_i_value = c.i_dep ? cases[int'(c.i_arg)].exp : c.i_arg;  // ignored while waiting
    disp_j_value = c.j_dep ? cases[int'(c.j_arg)].exp : c.j_arg;
    sb_pending[c.tag] = 1'b1;
    sb_row[c.tag]     = r;
    n_pending++;
    disp_valid = 1'b1;
    @(posedge clk_in);
    #1;
    disp_valid = 1'b0;
  endtask

  // handshakes are judged mid cycle and complete on the next rising edge
  always @(negedge clk_in) begin
    if (!rst_in) begin
      if (held_valid) begin
        if (!result_valid) begin
          errors++;
          $display("result for tag %0d withdrawn while stalled at %0t", held_tag, $time);
        end
        check_tag(result_tag, held_tag);
        check_value(result_value, held_value);
      end
      if (result_valid && result_ready) begin
        if (!sb_pending[result_tag]) begin
          errors++;
          $display("unexpected result for tag %0d at %0t", result_tag, $time);
        end else begin
          check_value(result_value, cases[sb_row[result_tag]].exp);
          row_done[sb_row[result_tag]] = 1'b1;
          sb_pending[result_tag]       = 1'b0;
          n_pending--;
          n_results++;
        end
      end
      held_valid = result_valid && !result_ready;
      held_tag   = result_tag;
      held_value = result_value;
    end
  end

  always @(posedge clk_in) begin : drive_result_ready
    logic [31:0] rnd;
    #1;
    rnd = next_random();
    if (hold_cnt > 0) begin
      hold_cnt--;
      result_ready = 1'b0;
    end else begin
      result_ready = rnd[9:8] != 2'b00;       // ready three cycles in four
      if (rnd[15:12] == 4'h0) hold_cnt = 10;   // now and then a long stall
    end
  end

  initial begin
    #((n_cases * 40 + 8) * 4);
    for (int t = 0; t < rob_size; t++) begin
      if (sb_pending[t]) $display("missing result for tag %0d", t);
    end
    $display("timeout at %0t, results %0d, errors %0d", $time, n_results, errors);
    $display("Test failures found");
    $finish;
  end

  initial begin
    for (int t = 0; t < rob_size; t++) sb_pending[t] = 1'b0;
    for (int r = 0; r < n_cases; r++) row_done[r] = 1'b0;
    load_cases();
    cross_check_table();
    repeat (8) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    if (!disp_ready || result_valid) begin
      errors++;
      $display("cluster not idle after reset at %0t", $time);
    end
    for (int r = 0; r < n_cases; r++) begin
      if (cases[r].flag[0]) begin
        while (n_pending != 0) @(negedge clk_in);
        hold_cnt = 24;  // producer of the next rows sits at the output
        @(posedge clk_in);
        #1;
      end
      dispatch_row(r);
      if (cases[r].flag[1] && disp_ready) begin
        errors++;
        $display("station still accepts with three rows waiting on a stalled producer");
      end
    end
    while (n_pending != 0) @(negedge clk_in);
    @(posedge clk_in);
    #1;
    if (!disp_ready) begin
      errors++;
      $display("disp_ready low after all results drained at %0t", $time);
    end
    $display("rows %0d, results %0d, errors %0d", n_cases, n_results, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: exec_cluster.f
+incdir+bench
design/exec_pkg.sv
design/issue_if.sv
design/reservation_station.sv
design/alu_pipe.sv
design/exec_cluster.sv
bench/exec_cluster_tb.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - design/exec_pkg.sv
  - design/issue_if.sv
  - design/reservation_station.sv
  - design/alu_pipe.sv
  - design/exec_cluster.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/exec_cluster_tb.sv
